/* source/mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam int imem_words = 64;
  typedef logic [$clog2(imem_words)-1:0] imem_addr_t;

  // alu operation codes
  typedef logic [2:0] alu_op_t;
  localparam alu_op_t alu_and = 3'b000;
  localparam alu_op_t alu_or  = 3'b001;
  localparam alu_op_t alu_add = 3'b010;
  localparam alu_op_t alu_sub = 3'b110;
  localparam alu_op_t alu_slt = 3'b111;

  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef logic [7:0] bus_ctl_t;
  localparam int ctl_wait = 0; // inbound only
  localparam int ctl_we   = 1; // host write in, cpu write out
  localparam int ctl_rd   = 2; // host read strobe

  typedef enum logic [2:0] {
    idle,
    addr,
    data,
    done,
    load_addr,
    load_data,
    read_out
  } bus_state_t;

endpackage

/* source/ctrl_if.sv */
`timescale 1ns/1ns

interface ctrl_if;
  logic              memtoreg;
  logic              alusrc;
  logic              regdst;
  logic              regwrite;
  logic              branch;
  logic              jump;
  mips_pkg::alu_op_t alu_op;

  modport ctrl (
    output memtoreg, alusrc, regdst, regwrite,
    output branch, jump, alu_op
  );

  modport dp (
    input memtoreg, alusrc, regdst, regwrite,
    input branch, jump, alu_op
  );

endinterface

/* source/controller.sv */
`timescale 1ns/1ns

module controller (
  input  logic [5:0] op,
  input  logic [5:0] funct,
  input  logic       zero,
  ctrl_if.ctrl       c,
  output logic       memop,
  output logic       memwrite
);

  always_comb begin
    c.memtoreg = 1'b0;
    c.alusrc   = 1'b0;
    c.regdst   = 1'b0;
    c.regwrite = 1'b0;
    c.branch   = 1'b0;
    c.jump     = 1'b0;
    c.alu_op   = mips_pkg::alu_add;
    memop      = 1'b0;
    memwrite   = 1'b0;
    case (op)
      mips_pkg::op_rtype: begin
        c.regdst   = 1'b1;
        c.regwrite = 1'b1;
        case (funct)
          mips_pkg::fn_addu: c.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: c.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  c.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   c.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt:  c.alu_op = mips_pkg::alu_slt;
          default:           c.regwrite = 1'b0; // unsupported funct is a nop
        endcase
      end
      mips_pkg::op_addiu: begin
        c.alusrc   = 1'b1;
        c.regwrite = 1'b1;
      end
      mips_pkg::op_lw: begin
        c.alusrc   = 1'b1;
        c.regwrite = 1'b1;
        c.memtoreg = 1'b1;
        memop      = 1'b1;
      end
      mips_pkg::op_sw: begin
        c.alusrc = 1'b1;
        memop    = 1'b1;
        memwrite = 1'b1;
      end
      mips_pkg::op_beq: begin
        c.alu_op = mips_pkg::alu_sub; // compare by subtraction
        c.branch = 1'b1;              // datapath qualifies with zero
      end
      mips_pkg::op_j: c.jump = 1'b1;
      default: ;
    endcase
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic                we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::reg_addr_t ra_dbg,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2,
  output mips_pkg::word_t     rd_dbg
);

  mips_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // r0 reads zero on every port
  assign rd1    = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2    = (ra2 == '0) ? '0 : regs[ra2];
  assign rd_dbg = (ra_dbg == '0) ? '0 : regs[ra_dbg];

endmodule

/* source/datapath.sv */
`timescale 1ns/1ns

module datapath (
  input  logic                clk,
  input  logic                rst,
  ctrl_if.dp                  c,
  input  logic                pc_stall,
  input  mips_pkg::word_t     instr,
  output mips_pkg::word_t     pc,
  output mips_pkg::word_t     alu_out,
  output mips_pkg::word_t     writedata,
  input  mips_pkg::word_t     readdata,
  output logic                zero,
  input  mips_pkg::reg_addr_t debug_ra4,
  output mips_pkg::word_t     debug_rd4
);

  mips_pkg::word_t     pc_plus4;
  mips_pkg::word_t     pc_branch;
  mips_pkg::word_t     pc_jump;
  mips_pkg::word_t     pc_next;
  mips_pkg::word_t     sign_imm;
  mips_pkg::word_t     src_a;
  mips_pkg::word_t     src_b;
  mips_pkg::word_t     result;
  mips_pkg::reg_addr_t wa;
  logic                reg_we;

  assign pc_plus4  = pc + 32'd4;
  assign sign_imm  = {{16{instr[15]}}, instr[15:0]};
  assign pc_branch = pc_plus4 + {sign_imm[29:0], 2'b00};
  assign pc_jump   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    if (c.jump) begin
      pc_next = pc_jump;
    end else if (c.branch && zero) begin
      pc_next = pc_branch;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // pc holds while the bus unit is busy
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!pc_stall) begin
      pc <= pc_next;
    end
  end

  assign wa     = c.regdst ? instr[15:11] : instr[20:16];
  assign reg_we = c.regwrite & ~pc_stall; // lw lands in the done cycle
  assign result = c.memtoreg ? readdata : alu_out;

  reg_file rf (
    .clk    (clk),
    .rst    (rst),
    .we     (reg_we),
    .ra1    (instr[25:21]),
    .ra2    (instr[20:16]),
    .wa     (wa),
    .ra_dbg (debug_ra4),
    .wd     (result),
    .rd1    (src_a),
    .rd2    (writedata),
    .rd_dbg (debug_rd4)
  );

  assign src_b = c.alusrc ? sign_imm : writedata;

  always_comb begin
    case (c.alu_op)
      mips_pkg::alu_and: alu_out = src_a & src_b;
      mips_pkg::alu_or:  alu_out = src_a | src_b;
      mips_pkg::alu_sub: alu_out = src_a - src_b;
      mips_pkg::alu_slt: alu_out = {31'b0, $signed(src_a) < $signed(src_b)};
      default:           alu_out = src_a + src_b;
    endcase
  end

  assign zero = (alu_out == '0);

endmodule

/* source/bus_unit.sv */
`timescale 1ns/1ns

module bus_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               memop,
  input  logic               memwrite,
  input  logic               bus_ack,
  input  mips_pkg::bus_ctl_t bus_ctrl_in,
  output logic               bus_req,
  output logic               bus_write,
  output logic               pc_stall,
  output logic               data_out,
  output logic               instr_out,
  output logic               instr_we,
  output logic               instr_addr_we
);

  mips_pkg::bus_state_t state;
  mips_pkg::bus_state_t state_nxt;
  logic                 bus_wait;
  logic                 host_we;
  logic                 host_rd;

  assign bus_wait = bus_ctrl_in[mips_pkg::ctl_wait];
  assign host_we  = bus_ctrl_in[mips_pkg::ctl_we];
  assign host_rd  = bus_ctrl_in[mips_pkg::ctl_rd];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mips_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt     = state;
    bus_req       = 1'b0;
    bus_write     = 1'b0;
    pc_stall      = 1'b1; // only idle and done let the pc move
    data_out      = 1'b0;
    instr_out     = 1'b0;
    instr_we      = 1'b0;
    instr_addr_we = 1'b0;
    case (state)
      mips_pkg::idle: begin
        // host requests win over a pending memory op
        if (host_we) begin
          instr_addr_we = 1'b1;
          state_nxt     = mips_pkg::load_addr;
        end else if (host_rd) begin
          instr_addr_we = 1'b1;
          state_nxt     = mips_pkg::read_out;
        end else if (memop) begin
          state_nxt = mips_pkg::addr;
        end else begin
          pc_stall = 1'b0;
        end
      end
      mips_pkg::addr: begin
        bus_req   = 1'b1;
        bus_write = memwrite;
        if (bus_ack) state_nxt = mips_pkg::data;
      end
      mips_pkg::data: begin
        bus_req   = 1'b1;
        bus_write = memwrite;
        data_out  = 1'b1;
        if (!bus_wait) state_nxt = mips_pkg::done;
      end
      mips_pkg::done: begin
        pc_stall  = 1'b0; // load data written back here
        state_nxt = mips_pkg::idle;
      end
      mips_pkg::load_addr: begin
        instr_we  = 1'b1; // data word follows the address word
        state_nxt = mips_pkg::idle;
      end
      mips_pkg::read_out: begin
        instr_out = 1'b1;
        state_nxt = mips_pkg::idle;
      end
      default: state_nxt = mips_pkg::idle;
    endcase
  end

endmodule

/* source/imem.sv */
`timescale 1ns/1ns

module imem (
  input  logic                 clk,
  input  mips_pkg::imem_addr_t addr_r,
  output mips_pkg::word_t      data_r,
  input  mips_pkg::imem_addr_t addr_h,
  output mips_pkg::word_t      data_h,
  input  mips_pkg::word_t      data_w,
  input  logic                 we
);

  mips_pkg::word_t mem [mips_pkg::imem_words];

  // fetch port
  assign data_r = mem[addr_r];

  // write and readback share the host address
  assign data_h = mem[addr_h];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr_h] <= data_w;
    end
  end

endmodule

/* source/mips.sv */
`timescale 1ns/1ns

module mips (
  input  logic                clk,
  input  logic                rst,
  input  mips_pkg::bus_ctl_t  bus_ctrl_in,
  input  logic                bus_ack,
  input  mips_pkg::reg_addr_t debug_ra4,
  output mips_pkg::bus_ctl_t  bus_ctrl_out,
  output logic                bus_req,
  output mips_pkg::word_t     debug_rd4,
  input  mips_pkg::word_t     bus_data_in,
  output mips_pkg::word_t     bus_data_out
);

  ctrl_if cif ();

  mips_pkg::word_t      pc;
  mips_pkg::word_t      instr;
  mips_pkg::word_t      alu_out;
  mips_pkg::word_t      writedata;
  mips_pkg::word_t      readdata;
  mips_pkg::word_t      imem_rd;
  mips_pkg::imem_addr_t instr_addr;
  logic                 zero;
  logic                 memop;
  logic                 memwrite;
  logic                 pc_stall;
  logic                 bus_write;
  logic                 data_out;
  logic                 instr_out;
  logic                 instr_we;
  logic                 instr_addr_we;

  // burst length field zero means single transfer
  always_comb begin
    bus_ctrl_out                   = '0;
    bus_ctrl_out[mips_pkg::ctl_we] = bus_write;
  end

  always_comb begin
    if (instr_out) begin
      bus_data_out = imem_rd;
    end else if (data_out) begin
      bus_data_out = writedata;
    end else begin
      bus_data_out = alu_out; // address phase
    end
  end

  // load data arrives one cycle before write-back
  always_ff @(posedge clk) begin
    readdata <= bus_data_in;
  end

  always_ff @(posedge clk) begin
    if (instr_addr_we) instr_addr <= bus_data_in[$bits(mips_pkg::imem_addr_t)-1:0];
  end

  controller ctl (
    .op       (instr[31:26]),
    .funct    (instr[5:0]),
    .zero     (zero),
    .c        (cif.ctrl),
    .memop    (memop),
    .memwrite (memwrite)
  );

  datapath dp (
    .clk       (clk),
    .rst       (rst),
    .c         (cif.dp),
    .pc_stall  (pc_stall),
    .instr     (instr),
    .pc        (pc),
    .alu_out   (alu_out),
    .writedata (writedata),
    .readdata  (readdata),
    .zero      (zero),
    .debug_ra4 (debug_ra4),
    .debug_rd4 (debug_rd4)
  );

  bus_unit bu (
    .clk           (clk),
    .rst           (rst),
    .memop         (memop),
    .memwrite      (memwrite),
    .bus_ack       (bus_ack),
    .bus_ctrl_in   (bus_ctrl_in),
    .bus_req       (bus_req),
    .bus_write     (bus_write),
    .pc_stall      (pc_stall),
    .data_out      (data_out),
    .instr_out     (instr_out),
    .instr_we      (instr_we),
    .instr_addr_we (instr_addr_we)
  );

  imem im (
    .clk    (clk),
    .addr_r (pc[7:2]),
    .data_r (instr),
    .addr_h (instr_addr),
    .data_h (imem_rd),
    .data_w (bus_data_in),
    .we     (instr_we)
  );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

/* testbench/mips_asserts.sv */
`timescale 1ns/1ns

module mips_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 bus_req,
  input logic                 pc_stall,
  input logic                 instr_we,
  input mips_pkg::bus_state_t state,
  input mips_pkg::bus_ctl_t   bus_ctrl_in
);

  // request held through addr and through data until wait drops
  req_held: assert property (@(posedge clk) disable iff (rst)
    (bus_req && !(state == mips_pkg::data && !bus_ctrl_in[mips_pkg::ctl_wait])) |=> bus_req)
    else $error("bus_req dropped before the data phase ended");

  stall_on_req: assert property (@(posedge clk) disable iff (rst) bus_req |-> pc_stall)
    else $error("pc_stall low while bus_req high");

  no_host_write: assert property (@(posedge clk) disable iff (rst) bus_req |-> !instr_we)
    else $error("imem host write during a cpu bus transaction");

endmodule

bind bus_unit mips_asserts asserts_i (.*);

/* testbench/tb_mips.sv */
`timescale 1ns/1ns

module tb_mips;

  localparam int prog_len = 16;
  localparam int nprog    = 4;
  localparam int wd_limit = 4 * nprog * prog_len * 12 + 500;

  logic clk, rst_clk, rst, rst_tb, bus_ack, bus_req, bm_wait;
  mips_pkg::bus_ctl_t  bus_ctrl_in, bus_ctrl_out, host_ctrl;
  mips_pkg::reg_addr_t debug_ra4;
  mips_pkg::word_t     debug_rd4, bus_data_in, bus_data_out, host_data, bm_data;

  logic [31:0]     seed;
  int              errors, failed;
  mips_pkg::word_t prog [prog_len];
  mips_pkg::word_t dmem [64];  // bus memory
  mips_pkg::word_t mdl_reg [32];
  mips_pkg::word_t q_addr [$];
  mips_pkg::word_t q_data [$];
  logic            q_we [$];

  assign rst         = rst_clk | rst_tb;
  assign bus_ctrl_in = host_ctrl | {7'b0, bm_wait};
  assign bus_data_in = host_data | bm_data;

  tb_clock clock_gen (.clk(clk), .rst(rst_clk));

  mips DUT (
    .clk(clk), .rst(rst), .bus_ctrl_in(bus_ctrl_in), .bus_ack(bus_ack),
    .debug_ra4(debug_ra4), .bus_ctrl_out(bus_ctrl_out), .bus_req(bus_req),
    .debug_rd4(debug_rd4), .bus_data_in(bus_data_in), .bus_data_out(bus_data_out)
  );

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      seed = seed[0] ? ((seed >> 1) ^ 32'h80200003) : (seed >> 1);  // galois step
      v = {v[30:0], seed[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic mips_pkg::word_t rand_alu();
    mips_pkg::reg_addr_t rs, rt, rd;
    logic [2:0]          k;
    rs = 5'(rnd(3));
    rt = 5'(rnd(3));
    rd = 5'(rnd(3));
    k  = 3'(rnd(3));
    case (k)
      3'd0: return {6'h00, rs, rt, rd, 5'h00, mips_pkg::fn_addu};
      3'd1: return {6'h00, rs, rt, rd, 5'h00, mips_pkg::fn_subu};
      3'd2: return {6'h00, rs, rt, rd, 5'h00, mips_pkg::fn_and};
      3'd3: return {6'h00, rs, rt, rd, 5'h00, mips_pkg::fn_or};
      3'd4: return {6'h00, rs, rt, rd, 5'h00, mips_pkg::fn_slt};
      default: return {mips_pkg::op_addiu, rs, rt, 16'(rnd(16))};
    endcase
  endfunction

  function automatic mips_pkg::word_t rand_mem(input logic we);
    mips_pkg::reg_addr_t rs, rt;
    rs = 5'(rnd(3));
    rt = 5'(rnd(3));
    return {we ? mips_pkg::op_sw : mips_pkg::op_lw, rs, rt, 8'h00, 6'(rnd(6)), 2'b00};
  endfunction

  task automatic gen_program(input int mode);
    int                  k, off;
    mips_pkg::reg_addr_t rs, rt;
    for (int i = 0; i < prog_len - 1; i++) begin
      k = int'(rnd(3));
      if (mode == 0 || (mode == 1 && k < 4) || (mode == 2 && k < 3) || (mode == 3 && k < 5)) begin
        prog[i] = rand_alu();
      end else if (mode == 1 || (mode == 2 && k < 5)) begin
        prog[i] = rand_mem(1'b1);
      end else if (mode == 2) begin
        prog[i] = rand_mem(1'b0);
      end else if (k < 7) begin
        rs = 5'(rnd(3));
        rt = rnd(1) ? rs : 5'(rnd(3));  // half the branches taken
        off = int'(rnd(2));
        if (i + 1 + off > prog_len - 1) off = prog_len - 2 - i;
        prog[i] = {mips_pkg::op_beq, rs, rt, 16'(off)};
      end else begin
        off = i + 2 + int'(rnd(2));
        if (off > prog_len - 1) off = prog_len - 1;
        prog[i] = {mips_pkg::op_j, 26'(off)};
      end
    end
    prog[prog_len-1] = {mips_pkg::op_j, 26'(prog_len - 1)};  // park here
  endtask

  // isa model that also returns a worst case cycle count
  task automatic run_model(output int worst);
    mips_pkg::word_t w, a, b, v, imm, mem [64];
    int              i, steps;
    mem = dmem;
    for (int r = 0; r < 32; r++) mdl_reg[r] = '0;
    i = 0;
    worst = 0;
    steps = 0;
    while (i != prog_len - 1 && steps < 100) begin
      w = prog[i];
      a = mdl_reg[w[25:21]];
      b = mdl_reg[w[20:16]];
      imm = {{16{w[15]}}, w[15:0]};
      worst += 1;
      steps++;
      i++;
      case (w[31:26])
        mips_pkg::op_rtype: begin
          case (w[5:0])
            mips_pkg::fn_addu: v = a + b;
            mips_pkg::fn_subu: v = a - b;
            mips_pkg::fn_and:  v = a & b;
            mips_pkg::fn_or:   v = a | b;
            default:           v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          endcase
          if (w[15:11] != 0) mdl_reg[w[15:11]] = v;
        end
        mips_pkg::op_addiu: if (w[20:16] != 0) mdl_reg[w[20:16]] = a + imm;
        mips_pkg::op_lw, mips_pkg::op_sw: begin
          worst += 8;  // 4 addr, 3 data, done
          v = (w[31:26] == mips_pkg::op_sw) ? b : mem[(a + imm) >> 2 & 32'h3f];
          if (w[31:26] == mips_pkg::op_sw) mem[(a + imm) >> 2 & 32'h3f] = v;
          else if (w[20:16] != 0) mdl_reg[w[20:16]] = v;
          q_addr.push_back(a + imm);
          q_data.push_back(v);
          q_we.push_back(w[31:26] == mips_pkg::op_sw);
        end
        mips_pkg::op_beq: if (a == b) i = i + int'($signed(w[15:0]));
        default: i = int'(w[25:0]);
      endcase
    end
  endtask

  // bus memory model with random ack delay and wait
  int              bphase, bdelay, bwait;
  mips_pkg::word_t baddr, bexp;
  logic            bwe;
  always @(posedge clk) begin
    #1;
    if (bphase == 0 && bus_req) begin
      bphase = 1;
      bdelay = int'(rnd(2));
      baddr = bus_data_out;
      bwe = bus_ctrl_out[mips_pkg::ctl_we];
      assert (q_addr.size() > 0) else begin
        $display("unexpected bus transaction at address %h", baddr);
        errors++;
      end
      if (q_addr.size() > 0) begin
        check_word("bus_data_out addr", baddr, q_addr.pop_front());
        check_word("bus_ctrl_out", 32'(bus_ctrl_out), {30'b0, q_we.pop_front(), 1'b0});
        bexp = q_data.pop_front();
      end
    end
    if (bphase == 1) begin
      if (bdelay == 0) begin
        bus_ack = 1'b1;
        bphase = 2;
        bwait = int'(rnd(2)) % 3;
      end else begin
        bdelay--;
      end
    end else if (bphase == 2) begin
      bus_ack = 1'b0;
      if (bwait > 0) begin
        bm_wait = 1'b1;
        bwait--;
      end else begin
        bm_wait = 1'b0;
        bphase = 0;
        if (bwe) begin
          check_word("bus_data_out store", bus_data_out, bexp);
          dmem[baddr[7:2]] = bus_data_out;
        end else begin
          bm_data = dmem[baddr[7:2]];
        end
      end
    end else begin
      bm_data = '0;
    end
  end

  task automatic host_write(input mips_pkg::imem_addr_t a, input mips_pkg::word_t w);
    host_ctrl = 8'h02;
    host_data = {26'b0, a};
    @(posedge clk) #1;
    host_ctrl = 8'h00;
    host_data = w;
    @(posedge clk) #1;
    host_data = '0;
  endtask

  task automatic check_regs();
    for (int r = 0; r < 32; r++) begin
      debug_ra4 = 5'(r);
      #1 check_word($sformatf("debug_rd4 r%0d", r), debug_rd4, mdl_reg[r]);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err0);
      failed++;
    end
  endtask

  task automatic run_program(input int mode);
    int worst;
    gen_program(mode);
    run_model(worst);
    @(posedge clk) #1 rst_tb = 1'b0;
    for (int i = 0; i < prog_len; i++) host_write(6'(i), prog[i]);
    rst_tb = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst_tb = 1'b0;
    repeat (worst + 4) @(posedge clk);
    #1;
    assert (q_addr.size() == 0) else begin
      $display("%0d expected bus transactions never happened", q_addr.size());
      errors++;
    end
    q_addr.delete();
    q_data.delete();
    q_we.delete();
    check_regs();
    rst_tb = 1'b1;
  endtask

  initial begin
    repeat (wd_limit) @(posedge clk);
    $display("watchdog: run exceeded %0d cycles", wd_limit);
    $display("sim failed");
    $finish;
  end

  initial begin
    int                   e0;
    mips_pkg::imem_addr_t ha [8];
    mips_pkg::word_t      img [64];
    string                names [4];
    names = '{"alu", "store", "load", "flow"};
    seed = 32'hff3ab7a0;
    errors = 0;
    failed = 0;
    rst_tb = 1'b1;
    host_ctrl = '0;
    host_data = '0;
    bm_data = '0;
    bm_wait = 1'b0;
    bus_ack = 1'b0;
    debug_ra4 = '0;
    bphase = 0;
    for (int i = 0; i < 64; i++) dmem[i] = (i * 32'h01000193) ^ 32'ha5c30f00;
    for (int r = 0; r < 32; r++) mdl_reg[r] = '0;
    repeat (2) @(posedge clk);
    #1;
    e0 = errors;
    check_word("bus_req", 32'(bus_req), 32'd0);
    check_word("bus_ctrl_out", 32'(bus_ctrl_out), 32'd0);
    check_regs();
    finish_test("reset", e0);

    e0 = errors;
    @(posedge clk) #1 rst_tb = 1'b0;
    for (int i = 0; i < 8; i++) begin
      ha[i] = 6'(rnd(6));
      img[ha[i]] = rnd(32);
      host_write(ha[i], img[ha[i]]);
    end
    for (int i = 0; i < 8; i++) begin
      host_ctrl = 8'h04;
      host_data = {26'b0, ha[i]};
      @(posedge clk) #1;
      host_ctrl = 8'h00;
      host_data = '0;
      check_word("bus_data_out readback", bus_data_out, img[ha[i]]);
      @(posedge clk) #1;
    end
    rst_tb = 1'b1;
    finish_test("host", e0);

    for (int m = 0; m < 4; m++) begin
      e0 = errors;
      repeat (nprog) run_program(m);
      finish_test(names[m], e0);
    end

    $display("tests: 6, failed: %0d, errors: %0d", failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* mips_sys.f */
source/mips_pkg.sv
source/ctrl_if.sv
source/controller.sv
source/reg_file.sv
source/datapath.sv
source/bus_unit.sv
source/imem.sv
source/mips.sv
testbench/tb_clock.sv
testbench/mips_asserts.sv
testbench/tb_mips.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= mips_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
